// File: files.f
verilog/axi_bridge_pkg.sv
verilog/req_arbiter.sv
verilog/read_fsm.sv
verilog/write_fsm.sv
verilog/write_tracker.sv
verilog/cpu_axi_bridge.sv
test/tb_axi_slave.sv
test/tb_bridge.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_bridge -f files.f -o sim_bridge \
    && ./obj_dir/sim_bridge | tee /dev/stderr | grep -qx "All checks passed" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

// File: test/tb_axi_slave.sv
`timescale 1ns/1ns

module tb_axi_slave (
    input  logic                    clk,
    input  logic                    reset,

    input  axi_bridge_pkg::axi_ar_t ar,
    input  logic                    arvalid,
    output logic                    arready,
    output axi_bridge_pkg::axi_r_t  r,
    output logic                    rvalid,
    input  logic                    rready,

    input  axi_bridge_pkg::axi_aw_t aw,
    input  logic                    awvalid,
    output logic                    awready,
    input  axi_bridge_pkg::axi_w_t  w,
    input  logic                    wvalid,
    output logic                    wready,
    output logic                    bvalid,
    input  logic                    bready
);

    logic [7:0]             mem [0:1023];
    integer                 seed = 25;
    logic [9:0]             wr_base;
    axi_bridge_pkg::axi_w_t w_q;
    logic                   aw_got;
    logic                   w_got;
    int                     b_owed;
    int                     b_wait;

    function automatic logic [7:0] fill_byte(int a);
        return 8'(a) ^ 8'((a >> 8) * 59);
    endfunction

    function automatic logic [31:0] read_word(logic [31:0] addr);
        logic [9:0] base;
        base = {addr[9:2], 2'b00};
        return {mem[base + 10'd3], mem[base + 10'd2], mem[base + 10'd1], mem[base]};
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[10'(i)] = fill_byte(i);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            r       <= '0;
            bvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_owed = 0;
            b_wait = 0;
        end else begin
            // ready lines come and go at random
            arready <= ($random(seed) & 1) == 1;
            awready <= ($random(seed) & 1) == 1;
            wready  <= ($random(seed) & 1) == 1;

            // one R beat the cycle after AR
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                r.id   <= ar.id;
                r.data <= read_word(ar.addr);
            end

            // commit once both AW and W are in
            if (aw_got && w_got) begin
                for (int j = 0; j < axi_bridge_pkg::STRB_W; j++) begin
                    if (w_q.strb[2'(j)]) begin
                        mem[wr_base + 10'(j)] = 8'(w_q.data >> (8 * j));
                    end
                end
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                if (b_owed == 0) begin
                    b_wait = $random(seed) & 15;
                end
                b_owed = b_owed + 1;
            end
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                wr_base <= {aw.addr[9:2], 2'b00};
            end
            if (wvalid && wready) begin
                w_got <= 1'b1;
                w_q   <= w;
            end

            // B after a random delay
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_owed = b_owed - 1;
                b_wait = $random(seed) & 15;
            end else if (!bvalid && b_owed > 0) begin
                if (b_wait == 0) begin
                    bvalid <= 1'b1;
                end else begin
                    b_wait = b_wait - 1;
                end
            end
        end
    end

endmodule

// File: test/tb_bridge.sv
`timescale 1ns/1ns

module tb_bridge;

    localparam int MAX_PW          = 4;
    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

    logic                      clk;
    logic                      reset;
    logic                      inst_req;
    axi_bridge_pkg::inst_cmd_t inst_cmd;
    logic                      inst_addr_ok;
    logic                      inst_data_ok;
    logic [31:0]               inst_rdata;
    logic                      data_req;
    axi_bridge_pkg::data_cmd_t data_cmd;
    logic                      data_addr_ok;
    logic                      data_data_ok;
    logic [31:0]               data_rdata;
    axi_bridge_pkg::axi_ar_t   ar;
    logic                      arvalid;
    logic                      arready;
    axi_bridge_pkg::axi_r_t    r;
    logic                      rvalid;
    logic                      rready;
    axi_bridge_pkg::axi_aw_t   aw;
    logic                      awvalid;
    logic                      awready;
    axi_bridge_pkg::axi_w_t    w;
    logic                      wvalid;
    logic                      wready;
    logic                      bvalid;
    logic                      bready;

    logic [7:0]  ref_mem [0:1023];
    int          mismatches = 0;
    int          failures = 0;

    // filled in by the monitor just before each rising edge
    int          inst_acc_cnt = 0;
    int          data_acc_cnt = 0;
    int          inst_ok_cnt = 0;
    int          data_ok_cnt = 0;
    int          data_ok_at_acc = 0;
    int          inst_acc_at_data_acc = 0;
    logic        inst_aok_at_data_acc = 1'b0;
    logic [31:0] inst_rdata_last = '0;
    logic [31:0] data_rdata_last = '0;

    // last address beats seen on the bus
    axi_bridge_pkg::axi_ar_t ar_last = '0;
    axi_bridge_pkg::axi_aw_t aw_last = '0;

    cpu_axi_bridge #(
        .MAX_PENDING_WRITES (MAX_PW)
    ) u_dut (
        .clk (clk), .reset (reset),
        .inst_req (inst_req), .inst_cmd (inst_cmd), .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok), .inst_rdata (inst_rdata),
        .data_req (data_req), .data_cmd (data_cmd), .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok), .data_rdata (data_rdata),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r (r), .rvalid (rvalid), .rready (rready),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready),
        .bvalid (bvalid), .bready (bready)
    );

    tb_axi_slave u_slave (
        .clk (clk), .reset (reset),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r (r), .rvalid (rvalid), .rready (rready),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready),
        .bvalid (bvalid), .bready (bready)
    );

    function automatic logic [7:0] init_pattern(int a);
        return 8'(a) ^ 8'((a >> 8) * 59);
    endfunction

    function automatic logic [31:0] ref_word(logic [31:0] addr);
        logic [9:0] base;
        base = {addr[9:2], 2'b00};
        return {ref_mem[base + 10'd3], ref_mem[base + 10'd2], ref_mem[base + 10'd1],
                ref_mem[base]};
    endfunction

    task automatic ref_write(logic [31:0] addr, logic [3:0] strb, logic [31:0] data);
        logic [9:0] base;
        base = {addr[9:2], 2'b00};
        for (int j = 0; j < 4; j++) begin
            if (strb[2'(j)]) begin
                ref_mem[base + 10'(j)] = 8'(data >> (8 * j));
            end
        end
    endtask

    task automatic report_mismatch(string test, logic [31:0] expected, logic [31:0] actual);
        $display("Mismatch in %s: expected %h, actual %h", test, expected, actual);
        mismatches++;
    endtask

    task automatic report_failure(string test, string what);
        $display("Failure in %s: %s", test, what);
        failures++;
    endtask

    // id in the upper nibble, size in the low three bits
    task automatic check_id_size(string test, logic [3:0] exp_id, logic [2:0] exp_size,
                                 logic [3:0] id, logic [2:0] size);
        if (id !== exp_id || size !== exp_size) begin
            report_mismatch(test, {25'd0, exp_id, exp_size}, {25'd0, id, size});
        end
    endtask

    // all driving tasks start and end on a falling edge
    task automatic issue_inst(logic [31:0] addr);
        int start;
        start = inst_acc_cnt;
        inst_req = 1'b1;
        inst_cmd.size = 2'd2;
        inst_cmd.addr = addr;
        @(negedge clk);
        while (inst_acc_cnt == start) @(negedge clk);
        inst_req = 1'b0;
    endtask

    task automatic issue_data(logic [31:0] addr, logic [1:0] size, logic [3:0] strb,
                              logic [31:0] data);
        int start;
        start = data_acc_cnt;
        data_req = 1'b1;
        data_cmd.size = size;
        data_cmd.addr = addr;
        data_cmd.wstrb = strb;
        data_cmd.wdata = data;
        @(negedge clk);
        while (data_acc_cnt == start) @(negedge clk);
        data_req = 1'b0;
    endtask

    task automatic wait_inst_ok(int target);
        while (inst_ok_cnt < target) @(negedge clk);
    endtask

    task automatic wait_data_ok(int target);
        while (data_ok_cnt < target) @(negedge clk);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic test_reset_idle();
        for (int k = 0; k < 8; k++) begin
            #4;
            if (inst_addr_ok || data_addr_ok || inst_data_ok || data_data_ok ||
                arvalid || rready || awvalid || wvalid || bready) begin
                report_failure("reset_idle", "an output went high with no request");
            end
            @(negedge clk);
        end
    endtask

    task automatic test_inst_read();
        int iok;
        int dok;
        iok = inst_ok_cnt;
        dok = data_ok_cnt;
        issue_inst(32'h0000_0040);
        wait_inst_ok(iok + 1);
        if (inst_rdata_last !== ref_word(32'h0000_0040)) begin
            report_mismatch("inst_read", ref_word(32'h0000_0040), inst_rdata_last);
        end
        check_id_size("inst_read ar id and size", 4'd0, 3'd2, ar_last.id, ar_last.size);
        idle_cycles(10);
        if (inst_ok_cnt != iok + 1) begin
            report_mismatch("inst_read inst_data_ok count", iok + 1, inst_ok_cnt);
        end
        if (data_ok_cnt != dok) begin
            report_mismatch("inst_read data_data_ok count", dok, data_ok_cnt);
        end
    endtask

    task automatic test_write_read();
        int dok;
        int iok;
        logic [31:0] base;
        dok = data_ok_cnt;
        iok = inst_ok_cnt;
        base = 32'h0000_0104;
        // halfword into the upper lanes, then one byte
        issue_data(base + 32'd2, 2'd1, 4'b1100, 32'hbeef_0000);
        ref_write(base, 4'b1100, 32'hbeef_0000);
        wait_data_ok(dok + 1);
        check_id_size("write_read aw halfword", 4'd1, 3'd1, aw_last.id, aw_last.size);
        issue_data(base + 32'd1, 2'd0, 4'b0010, 32'h0000_7700);
        ref_write(base, 4'b0010, 32'h0000_7700);
        wait_data_ok(dok + 2);
        check_id_size("write_read aw byte", 4'd1, 3'd0, aw_last.id, aw_last.size);
        issue_data(base, 2'd2, 4'b0000, 32'h0);
        wait_data_ok(dok + 3);
        if (data_rdata_last !== ref_word(base)) begin
            report_mismatch("write_read", ref_word(base), data_rdata_last);
        end
        check_id_size("write_read ar id and size", 4'd1, 3'd2, ar_last.id, ar_last.size);
        idle_cycles(10);
        if (data_ok_cnt != dok + 3) begin
            report_mismatch("write_read data_data_ok count", dok + 3, data_ok_cnt);
        end
        if (inst_ok_cnt != iok) begin
            report_mismatch("write_read inst_data_ok count", iok, inst_ok_cnt);
        end
    endtask

    task automatic test_priority();
        int inst_start;
        int data_start;
        int iok;
        int dok;
        inst_start = inst_acc_cnt;
        data_start = data_acc_cnt;
        iok = inst_ok_cnt;
        dok = data_ok_cnt;
        inst_req = 1'b1;
        inst_cmd.size = 2'd2;
        inst_cmd.addr = 32'h0000_0080;
        data_req = 1'b1;
        data_cmd.size = 2'd2;
        data_cmd.addr = 32'h0000_0090;
        data_cmd.wstrb = 4'b0000;
        data_cmd.wdata = '0;
        while (inst_req || data_req) begin
            @(negedge clk);
            if (data_acc_cnt != data_start) data_req = 1'b0;
            if (inst_acc_cnt != inst_start) inst_req = 1'b0;
        end
        if (inst_acc_at_data_acc != inst_start) begin
            report_failure("priority", "instruction request accepted before data request");
        end
        if (inst_aok_at_data_acc !== 1'b0) begin
            report_mismatch("priority inst_addr_ok", 32'd0, {31'd0, inst_aok_at_data_acc});
        end
        wait_data_ok(dok + 1);
        wait_inst_ok(iok + 1);
        if (data_rdata_last !== ref_word(32'h0000_0090)) begin
            report_mismatch("priority data word", ref_word(32'h0000_0090), data_rdata_last);
        end
        if (inst_rdata_last !== ref_word(32'h0000_0080)) begin
            report_mismatch("priority inst word", ref_word(32'h0000_0080), inst_rdata_last);
        end
    endtask

    task automatic test_posted_writes();
        int dok;
        logic [31:0] addr;
        logic [31:0] val;
        dok = data_ok_cnt;
        addr = 32'h0000_0200;
        for (int i = 0; i <= MAX_PW; i++) begin
            val = 32'h5a00_0000 | (32'h0001_0101 * 32'(i + 1));
            issue_data(addr, 2'd2, 4'b1111, val);
            ref_write(addr, 4'b1111, val);
        end
        // the extra write needs a free slot
        if (data_ok_at_acc - dok < 1) begin
            report_failure("posted_writes", "last write accepted with no B response yet");
        end
        issue_data(addr, 2'd2, 4'b0000, 32'h0);
        if (data_ok_at_acc - dok != MAX_PW + 1) begin
            report_mismatch("posted_writes data_ok before read", MAX_PW + 1,
                            data_ok_at_acc - dok);
        end
        wait_data_ok(dok + MAX_PW + 2);
        if (data_rdata_last !== ref_word(addr)) begin
            report_mismatch("posted_writes read", ref_word(addr), data_rdata_last);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        forever begin
            @(negedge clk);
            #4;
            if (data_addr_ok) begin
                data_acc_cnt++;
                data_ok_at_acc = data_ok_cnt;
                inst_acc_at_data_acc = inst_acc_cnt;
                inst_aok_at_data_acc = inst_addr_ok;
            end
            if (inst_addr_ok) inst_acc_cnt++;
            if (inst_data_ok) begin
                inst_ok_cnt++;
                inst_rdata_last = inst_rdata;
            end
            if (data_data_ok) begin
                data_ok_cnt++;
                data_rdata_last = data_rdata;
            end
            if (arvalid && arready) begin
                ar_last = ar;
            end
            if (awvalid && awready) begin
                aw_last = aw;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog timeout after %0d cycles, a test never finished", WATCHDOG_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("Checks failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        inst_req = 1'b0;
        inst_cmd = '0;
        data_req = 1'b0;
        data_cmd = '0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[10'(i)] = init_pattern(i);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_idle();
        test_inst_read();
        test_write_read();
        test_priority();
        test_posted_writes();

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog/axi_bridge_pkg.sv
package axi_bridge_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    // 0 byte, 1 halfword, 2 word
    typedef logic [1:0] sram_size_t;

    typedef enum logic [ID_W-1:0] {
        ID_INST = ID_W'(0),
        ID_DATA = ID_W'(1)
    } axi_id_e;

    // processor side requests
    typedef struct packed {
        sram_size_t        size;
        logic [ADDR_W-1:0] addr;
    } inst_cmd_t;

    typedef struct packed {
        sram_size_t        size;
        logic [ADDR_W-1:0] addr;
        logic [STRB_W-1:0] wstrb;
        logic [DATA_W-1:0] wdata;
    } data_cmd_t;

    // arbiter to the two paths
    typedef struct packed {
        axi_id_e           id;
        sram_size_t        size;
        logic [ADDR_W-1:0] addr;
    } rd_cmd_t;

    typedef struct packed {
        sram_size_t        size;
        logic [ADDR_W-1:0] addr;
        logic [STRB_W-1:0] wstrb;
        logic [DATA_W-1:0] wdata;
    } wr_cmd_t;

    // axi channels, single beat only
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [2:0]        size;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [2:0]        size;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
    } axi_r_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef enum logic {
        WR_IDLE,
        WR_SEND
    } wr_state_e;

endpackage

// File: verilog/cpu_axi_bridge.sv
`timescale 1ns/1ns

module cpu_axi_bridge #(
    parameter int MAX_PENDING_WRITES = 4
) (
    input  logic                              clk,
    input  logic                              reset,

    // instruction port, read only
    input  logic                              inst_req,
    input  axi_bridge_pkg::inst_cmd_t         inst_cmd,
    output logic                              inst_addr_ok,
    output logic                              inst_data_ok,
    output logic [axi_bridge_pkg::DATA_W-1:0] inst_rdata,

    // data port
    input  logic                              data_req,
    input  axi_bridge_pkg::data_cmd_t         data_cmd,
    output logic                              data_addr_ok,
    output logic                              data_data_ok,
    output logic [axi_bridge_pkg::DATA_W-1:0] data_rdata,

    // axi read
    output axi_bridge_pkg::axi_ar_t           ar,
    output logic                              arvalid,
    input  logic                              arready,
    input  axi_bridge_pkg::axi_r_t            r,
    input  logic                              rvalid,
    output logic                              rready,

    // axi write
    output axi_bridge_pkg::axi_aw_t           aw,
    output logic                              awvalid,
    input  logic                              awready,
    output axi_bridge_pkg::axi_w_t            w,
    output logic                              wvalid,
    input  logic                              wready,
    input  logic                              bvalid,
    output logic                              bready
);

    logic                              rd_start;
    axi_bridge_pkg::rd_cmd_t           rd_cmd;
    logic                              wr_start;
    axi_bridge_pkg::wr_cmd_t           wr_cmd;
    logic                              rd_idle;
    logic                              wr_idle;
    logic                              aw_done;
    logic                              writes_pending;
    logic                              write_full;
    logic                              rd_data_ok;
    logic                              wr_data_ok;
    logic [axi_bridge_pkg::DATA_W-1:0] rd_rdata;

    req_arbiter u_arbiter (
        .clk            (clk),
        .reset          (reset),
        .inst_req       (inst_req),
        .inst_cmd       (inst_cmd),
        .data_req       (data_req),
        .data_cmd       (data_cmd),
        .rd_idle        (rd_idle),
        .wr_idle        (wr_idle),
        .writes_pending (writes_pending),
        .write_full     (write_full),
        .inst_addr_ok   (inst_addr_ok),
        .data_addr_ok   (data_addr_ok),
        .rd_start       (rd_start),
        .rd_cmd         (rd_cmd),
        .wr_start       (wr_start),
        .wr_cmd         (wr_cmd)
    );

    read_fsm u_read (
        .clk          (clk),
        .reset        (reset),
        .rd_start     (rd_start),
        .rd_cmd       (rd_cmd),
        .rd_idle      (rd_idle),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .inst_data_ok (inst_data_ok),
        .data_data_ok (rd_data_ok),
        .rdata        (rd_rdata)
    );

    write_fsm u_write (
        .clk      (clk),
        .reset    (reset),
        .wr_start (wr_start),
        .wr_cmd   (wr_cmd),
        .wr_idle  (wr_idle),
        .aw_done  (aw_done),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready)
    );

    write_tracker #(
        .MAX_PENDING_WRITES (MAX_PENDING_WRITES)
    ) u_tracker (
        .clk            (clk),
        .reset          (reset),
        .aw_done        (aw_done),
        .bvalid         (bvalid),
        .bready         (bready),
        .data_data_ok   (wr_data_ok),
        .writes_pending (writes_pending),
        .write_full     (write_full)
    );

    // read and B never land in the same cycle
    assign data_data_ok = rd_data_ok | wr_data_ok;
    assign data_rdata   = rd_rdata;
    assign inst_rdata   = rd_rdata;

endmodule

// File: verilog/read_fsm.sv
`timescale 1ns/1ns

module read_fsm (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              rd_start,
    input  axi_bridge_pkg::rd_cmd_t           rd_cmd,
    output logic                              rd_idle,

    output axi_bridge_pkg::axi_ar_t           ar,
    output logic                              arvalid,
    input  logic                              arready,
    input  axi_bridge_pkg::axi_r_t            r,
    input  logic                              rvalid,
    output logic                              rready,

    output logic                              inst_data_ok,
    output logic                              data_data_ok,
    output logic [axi_bridge_pkg::DATA_W-1:0] rdata
);

    axi_bridge_pkg::rd_state_e state;
    axi_bridge_pkg::rd_cmd_t   cmd_q;
    logic                      r_fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= axi_bridge_pkg::RD_IDLE;
        end else begin
            unique case (state)
                axi_bridge_pkg::RD_IDLE: begin
                    if (rd_start) begin
                        state <= axi_bridge_pkg::RD_ADDR;
                    end
                end
                axi_bridge_pkg::RD_ADDR: begin
                    if (arready) begin
                        state <= axi_bridge_pkg::RD_DATA;
                    end
                end
                axi_bridge_pkg::RD_DATA: begin
                    if (rvalid) begin
                        state <= axi_bridge_pkg::RD_IDLE;
                    end
                end
                default: state <= axi_bridge_pkg::RD_IDLE;
            endcase
        end
    end

    // command held for the whole transfer
    always_ff @(posedge clk) begin
        if (rd_start && state == axi_bridge_pkg::RD_IDLE) begin
            cmd_q <= rd_cmd;
        end
    end

    assign rd_idle = (state == axi_bridge_pkg::RD_IDLE);
    assign arvalid = (state == axi_bridge_pkg::RD_ADDR);
    assign rready  = (state == axi_bridge_pkg::RD_DATA);

    assign ar.id   = cmd_q.id;
    assign ar.addr = cmd_q.addr;
    assign ar.size = {1'b0, cmd_q.size};

    // route the beat by its id
    assign r_fire       = rvalid && rready;
    assign inst_data_ok = r_fire && (r.id == axi_bridge_pkg::ID_INST);
    assign data_data_ok = r_fire && (r.id == axi_bridge_pkg::ID_DATA);
    assign rdata        = r.data;

    a_ar_stable: assert property (
        @(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(ar)
    ) else $error("AR changed before arready");

    a_no_stray_r: assert property (
        @(posedge clk) disable iff (reset)
        rvalid |-> state != axi_bridge_pkg::RD_IDLE
    ) else $error("rvalid with no read outstanding");

endmodule

// File: verilog/req_arbiter.sv
`timescale 1ns/1ns

module req_arbiter (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    inst_req,
    input  axi_bridge_pkg::inst_cmd_t inst_cmd,
    input  logic                    data_req,
    input  axi_bridge_pkg::data_cmd_t data_cmd,

    input  logic                    rd_idle,
    input  logic                    wr_idle,
    input  logic                    writes_pending,
    input  logic                    write_full,

    output logic                    inst_addr_ok,
    output logic                    data_addr_ok,

    output logic                    rd_start,
    output axi_bridge_pkg::rd_cmd_t rd_cmd,
    output logic                    wr_start,
    output axi_bridge_pkg::wr_cmd_t wr_cmd
);

    logic data_is_wr;
    logic rd_ready;
    logic wr_ready;
    logic data_rd_grant;
    logic data_wr_grant;
    logic inst_grant;

    // same rule as the core, a store has some strobe set
    assign data_is_wr = |data_cmd.wstrb;

    // a write still in AW/W counts as pending for reads
    assign rd_ready = rd_idle && wr_idle && !writes_pending;
    // keeps read and B responses apart on data_ok
    assign wr_ready = wr_idle && !write_full && rd_idle;

    assign data_rd_grant = data_req && !data_is_wr && rd_ready;
    assign data_wr_grant = data_req && data_is_wr && wr_ready;

    // inst only gets the slot when data takes nothing
    assign inst_grant = inst_req && !data_rd_grant && !data_wr_grant && rd_ready;

    assign data_addr_ok = data_rd_grant || data_wr_grant;
    assign inst_addr_ok = inst_grant;

    assign rd_start    = data_rd_grant || inst_grant;
    assign rd_cmd.id   = data_rd_grant ? axi_bridge_pkg::ID_DATA : axi_bridge_pkg::ID_INST;
    assign rd_cmd.size = data_rd_grant ? data_cmd.size : inst_cmd.size;
    assign rd_cmd.addr = data_rd_grant ? data_cmd.addr : inst_cmd.addr;

    assign wr_start     = data_wr_grant;
    assign wr_cmd.size  = data_cmd.size;
    assign wr_cmd.addr  = data_cmd.addr;
    assign wr_cmd.wstrb = data_cmd.wstrb;
    assign wr_cmd.wdata = data_cmd.wdata;

    a_one_grant: assert property (
        @(posedge clk) disable iff (reset)
        !(rd_start && wr_start)
    ) else $error("read and write granted in the same cycle");

endmodule

// File: verilog/write_fsm.sv
`timescale 1ns/1ns

module write_fsm (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    wr_start,
    input  axi_bridge_pkg::wr_cmd_t wr_cmd,
    output logic                    wr_idle,
    output logic                    aw_done,

    output axi_bridge_pkg::axi_aw_t aw,
    output logic                    awvalid,
    input  logic                    awready,
    output axi_bridge_pkg::axi_w_t  w,
    output logic                    wvalid,
    input  logic                    wready
);

    axi_bridge_pkg::wr_state_e state;
    axi_bridge_pkg::wr_cmd_t   cmd_q;
    logic                      aw_ok;
    logic                      w_ok;
    logic                      aw_now;
    logic                      w_now;
    logic                      sending;

    assign sending = (state == axi_bridge_pkg::WR_SEND);

    // AW and W finish independently, in any order
    assign awvalid = sending && !aw_ok;
    assign wvalid  = sending && !w_ok;
    assign aw_now  = aw_ok || (awvalid && awready);
    assign w_now   = w_ok || (wvalid && wready);
    assign aw_done = sending && aw_now && w_now;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= axi_bridge_pkg::WR_IDLE;
            aw_ok <= 1'b0;
            w_ok  <= 1'b0;
        end else begin
            unique case (state)
                axi_bridge_pkg::WR_IDLE: begin
                    aw_ok <= 1'b0;
                    w_ok  <= 1'b0;
                    if (wr_start) begin
                        state <= axi_bridge_pkg::WR_SEND;
                    end
                end
                axi_bridge_pkg::WR_SEND: begin
                    aw_ok <= aw_now;
                    w_ok  <= w_now;
                    if (aw_done) begin
                        state <= axi_bridge_pkg::WR_IDLE;
                    end
                end
                default: state <= axi_bridge_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start && !sending) begin
            cmd_q <= wr_cmd;
        end
    end

    assign wr_idle = !sending;

    // only the data port writes
    assign aw.id   = axi_bridge_pkg::ID_DATA;
    assign aw.addr = cmd_q.addr;
    assign aw.size = {1'b0, cmd_q.size};
    assign w.data  = cmd_q.wdata;
    assign w.strb  = cmd_q.wstrb;

    a_aw_stable: assert property (
        @(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(aw)
    ) else $error("AW changed before awready");

endmodule

// File: verilog/write_tracker.sv
`timescale 1ns/1ns

module write_tracker #(
    parameter int MAX_PENDING_WRITES = 4
) (
    input  logic clk,
    input  logic reset,

    input  logic aw_done,
    input  logic bvalid,
    output logic bready,

    output logic data_data_ok,
    output logic writes_pending,
    output logic write_full
);

    localparam int CNT_W = $clog2(MAX_PENDING_WRITES + 1);

    logic [CNT_W-1:0] count;
    logic             b_fire;

    assign bready = (count != '0);
    assign b_fire = bvalid && bready;

    // up when a write leaves AW/W, down on each B
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            unique case ({aw_done, b_fire})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    assign data_data_ok   = b_fire;
    assign writes_pending = (count != '0);
    assign write_full     = (count == CNT_W'(MAX_PENDING_WRITES));

    a_no_stray_b: assert property (
        @(posedge clk) disable iff (reset)
        bvalid |-> count != '0
    ) else $error("bvalid with no write outstanding");

endmodule
